//--- files.f
hw/exec_pkg.sv
hw/alu_unit.sv
hw/shift_unit.sv
hw/branch_unit.sv
hw/lsu_unit.sv
hw/execute_stage.sv
hw/retire_stage.sv
hw/exec_top.sv
tests/data_mem_model.sv
tests/tb_exec.sv

//--- tests/tb_exec.sv
//////////////////////////////////////////////////
// Drives exec_top with a random instruction stream and checks it
// against a reference model that keeps its own memory shadow
//////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_exec;

    import exec_pkg::*;

    localparam int TAG_W = 4;

    typedef struct packed {
        int               due;               // Cycle of the write-back
        logic [2:0]       tid;               // Test index
        logic             we;
        logic             jump;
        logic             rd;                // Request seen one cycle earlier
        be_t              be;
        word_t            addr;              // Memory word address
        word_t            wdata;             // Store data on its lanes
        word_t            data;
        word_t            target;
        logic [TAG_W-1:0] tag;
    } exp_t;

    logic             clk;
    logic             rst_n_i;
    word_t            npc_i, op_a_i, op_b_i, op_c_i;
    instr_e           instr_i;
    xu_e              xu_sel_i;
    logic [TAG_W-1:0] tag_i;
    word_t            mem_addr_o, mem_wdata_o, mem_rdata_i, wb_data_o, jump_target_o;
    logic             mem_rd_o, wb_we_o, jump_o;
    be_t              mem_be_o;
    logic [TAG_W-1:0] wb_tag_o;

    logic [7:0]       shadow [0:1023];       // Reference copy of the data memory
    exp_t             exp_q [$];             // Expected results in issue order
    int               cyc = 0;
    int               errors = 0;            // Wrong values
    int               fails = 0;             // Timeouts and lost results
    logic [TAG_W-1:0] tag_cnt = '0;

    exec_top u_dut (
        .clk(clk), .rst_n_i(rst_n_i), .npc_i(npc_i),
        .op_a_i(op_a_i), .op_b_i(op_b_i), .op_c_i(op_c_i),
        .instr_i(instr_i), .xu_sel_i(xu_sel_i), .tag_i(tag_i),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o), .mem_rd_o(mem_rd_o),
        .mem_be_o(mem_be_o), .mem_rdata_i(mem_rdata_i),
        .wb_we_o(wb_we_o), .wb_data_o(wb_data_o), .wb_tag_o(wb_tag_o),
        .jump_o(jump_o), .jump_target_o(jump_target_o)
    );

    data_mem_model #(.DEPTH(256)) u_mem (
        .clk(clk), .addr_i(mem_addr_o), .rd_i(mem_rd_o), .be_i(mem_be_o),
        .wdata_i(mem_wdata_o), .rdata_o(mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;              // 20 ns period
    end

    initial begin
        rst_n_i = 1'b0;
        repeat (5) @(posedge clk);
        #2 rst_n_i = 1'b1;
    end

    always @(posedge clk) cyc <= cyc + 1;

    ////////// Reference model ////////////////////////
    function automatic logic [7:0] fill_byte(input logic [9:0] x);
        return x[7:0] ^ {4{x[9:8]}} ^ 8'ha5;  // Differs across the whole address
    endfunction

    function automatic xu_e unit_for(input instr_e ins);
        case (ins)
            ADD, SUB, SLT, SLTU:              return XU_ADDER;
            XOR, OR, AND:                     return XU_LOGIC;
            SLL, SRL, SRA:                    return XU_SHIFT;
            LB, LBU, LH, LHU, LW, SB, SH, SW: return XU_MEMORY;
            PASS, NOTOKEN:                    return XU_BYPASS;
            default:                          return XU_BRANCH;
        endcase
    endfunction

    function automatic exp_t predict(input instr_e ins, input xu_e sel, input word_t npc,
                                     input word_t a, input word_t b, input word_t c);
        exp_t        e;
        word_t       ea;
        logic [9:0]  ba;
        int          sh;
        logic [7:0]  byt;
        logic [15:0] hw;
        be_t         sbe;
        word_t       swd;
        e   = '0;
        ea  = a + b;
        ba  = ea[9:0];
        sh  = b[4:0];
        sbe = '0;
        swd = '0;
        if (ins == NOTOKEN || unit_for(ins) != sel)
            return e;                        // Bubble or wrong unit
        e.we = 1'b1;
        case (ins)
            ADD:  e.data = a + b;
            SUB:  e.data = a - b;
            SLT:  e.data = {31'd0, $signed(a) < $signed(b)};
            SLTU: e.data = {31'd0, a < b};
            XOR:  e.data = a ^ b;
            OR:   e.data = a | b;
            AND:  e.data = a & b;
            SLL:  e.data = a << sh;
            SRL:  e.data = a >> sh;
            SRA:  e.data = $signed(a) >>> sh;
            PASS: e.data = b;
            BEQ:  e.jump = (a == b);
            BNE:  e.jump = (a != b);
            BLT:  e.jump = ($signed(a) < $signed(b));
            BGE:  e.jump = ($signed(a) >= $signed(b));
            BLTU: e.jump = (a < b);
            BGEU: e.jump = (a >= b);
            JAL, JALR: e.jump = 1'b1;
            LB, LBU: begin
                byt    = shadow[ba];
                e.data = (ins == LB) ? {{24{byt[7]}}, byt} : {24'd0, byt};
            end
            LH, LHU: begin
                hw     = {shadow[{ba[9:1], 1'b1}], shadow[{ba[9:1], 1'b0}]}; // Aligned down
                e.data = (ins == LH) ? {{16{hw[15]}}, hw} : {16'd0, hw};
            end
            LW: e.data = {shadow[{ba[9:2], 2'd3}], shadow[{ba[9:2], 2'd2}],
                          shadow[{ba[9:2], 2'd1}], shadow[{ba[9:2], 2'd0}]};
            SB: begin
                shadow[ba]                    = c[7:0];
                sbe[ba[1:0]]                  = 1'b1;      // Lane of the byte written
                swd[{ba[1:0], 3'b000} +: 8]   = c[7:0];
            end
            SH: begin
                shadow[{ba[9:1], 1'b0}]       = c[7:0];
                shadow[{ba[9:1], 1'b1}]       = c[15:8];
                sbe[{ba[1], 1'b0}]            = 1'b1;
                sbe[{ba[1], 1'b1}]            = 1'b1;
                swd[{ba[1], 4'b0000} +: 16]   = c[15:0];
            end
            default: begin
                for (int k = 0; k < 4; k++)
                    shadow[{ba[9:2], 2'b00} + k] = c[8*k +: 8];   // SW
                sbe = 4'b1111;
                swd = c;
            end
        endcase
        if (unit_for(ins) == XU_MEMORY) begin
            e.be    = sbe;
            e.wdata = swd;
            e.addr  = {ea[31:2], 2'b00};
            e.rd    = (sbe == 4'b0000);      // Loads read, stores write
            e.we    = e.rd;
        end
        if (unit_for(ins) == XU_BRANCH) begin
            e.we     = (ins == JAL) || (ins == JALR);
            e.data   = npc;                  // Link
            e.target = (ins == JALR) ? ((a + c) & 32'hffff_fffe) : (npc - 32'd4 + c);
        end
        return e;
    endfunction

    function automatic string test_name(input logic [2:0] tid);
        case (tid)
            3'd0:    return "idle";
            3'd1:    return "arith";
            3'd2:    return "branch";
            3'd3:    return "load_store";
            3'd4:    return "bad_select";
            default: return "random_mix";
        endcase
    endfunction

    ////////// Compare tasks //////////////////////////
    task automatic check_word(input string t, input string what, input word_t exp,
                              input word_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s %s expected %h actual %h", t, what, exp, act);
        end
    endtask

    task automatic check_flag(input string t, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            errors++;
            $display("error %s %s expected %b actual %b", t, what, exp, act);
        end
    endtask

    task automatic check_tag(input string t, input logic [TAG_W-1:0] exp,
                             input logic [TAG_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("error %s wb_tag expected %h actual %h", t, exp, act);
        end
    endtask

    task automatic check_be(input string t, input be_t exp, input be_t act);
        if (act !== exp) begin
            errors++;
            $display("error %s mem_be expected %b actual %b", t, exp, act);
        end
    endtask

    ////////// Stimulus ///////////////////////////////
    task automatic issue(input int tid, input instr_e ins, input xu_e sel,
                         input word_t a, input word_t b);
        exp_t  e;
        word_t npc;
        word_t c;
        npc = $urandom & 32'hffff_fffc;
        c   = $urandom;
        @(posedge clk);
        #2;
        npc_i    = npc;
        op_a_i   = a;
        op_b_i   = b;
        op_c_i   = c;
        instr_i  = ins;
        xu_sel_i = sel;
        tag_i    = tag_cnt;
        e        = predict(ins, sel, npc, a, b, c);
        e.due    = cyc + 2;                  // Two-cycle latency
        e.tid    = tid;
        e.tag    = tag_cnt;
        exp_q.push_back(e);
        tag_cnt++;
    endtask

    task automatic run_tests();
        word_t  a;
        word_t  b;
        instr_e ins;
        repeat (8) issue(0, NOTOKEN, XU_BYPASS, $urandom, $urandom);
        for (int i = 0; i < 60; i++) begin
            ins = (i % 11 == 10) ? PASS : instr_e'(1 + $urandom % 10);
            b   = (i % 4 == 0) ? $urandom % 40 : $urandom;
            issue(1, ins, unit_for(ins), $urandom, b);
        end
        for (int i = 0; i < 48; i++) begin
            a = $urandom;
            case (i / 8 % 3)
                0:       b = $urandom;
                1:       b = a;                       // Equal operands
                default: b = a ^ 32'h8000_0000;       // Signed and unsigned order differ
            endcase
            issue(2, instr_e'(11 + i % 8), XU_BRANCH, a, b);
        end
        for (int i = 0; i < 30; i++) begin
            a = ($urandom % 128) * 4;                 // Aligned base keeps the word
            b = $urandom % 512;
            issue(3, instr_e'(24 + i % 3), XU_MEMORY, a, b);
            issue(3, instr_e'(19 + i % 5), XU_MEMORY, a, b ^ ($urandom % 4));
        end
        for (int i = 0; i < 24; i++) begin
            ins = instr_e'(1 + $urandom % 27);
            issue(4, ins, xu_e'((unit_for(ins) + 1 + $urandom % 5) % 6),
                  $urandom % 512, $urandom % 512);
        end
        for (int i = 0; i < 300; i++) begin
            ins = instr_e'($urandom % 28);
            a   = $urandom;
            b   = $urandom;
            if (unit_for(ins) == XU_MEMORY) begin
                a = $urandom % 512;
                b = $urandom % 512;
            end
            issue(5, ins, ($urandom % 10 == 0) ? xu_e'($urandom % 6) : unit_for(ins), a, b);
        end
        repeat (4) issue(0, NOTOKEN, XU_BYPASS, '0, '0);  // Flush the pipe
    endtask

    ////////// Compare process ////////////////////////
    initial begin : compare
        exp_t  e;
        string t;
        word_t lanes;
        forever begin
            @(negedge clk);
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                e = exp_q.pop_front();
                t = test_name(e.tid);
                check_flag(t, "wb_we", e.we, wb_we_o);
                check_flag(t, "jump", e.jump, jump_o);
                check_tag(t, e.tag, wb_tag_o);
                if (e.we)
                    check_word(t, "wb_data", e.data, wb_data_o);
                if (e.jump)
                    check_word(t, "jump_target", e.target, jump_target_o);
            end
            if (exp_q.size() > 0 && exp_q[0].due == cyc + 1) begin
                e = exp_q[0];                // Memory request of the next result
                t = test_name(e.tid);
                check_flag(t, "mem_rd", e.rd, mem_rd_o);
                check_be(t, e.be, mem_be_o);
                if (e.rd || e.be != 4'b0000)
                    check_word(t, "mem_addr", e.addr, mem_addr_o);
                if (e.be != 4'b0000) begin
                    lanes = {{8{e.be[3]}}, {8{e.be[2]}}, {8{e.be[1]}}, {8{e.be[0]}}};
                    check_word(t, "mem_wdata", e.wdata & lanes, mem_wdata_o & lanes);
                end
            end
        end
    end

    initial begin : main
        int n;
        void'($urandom(32'he950_b67a));
        npc_i    = '0;
        op_a_i   = '0;
        op_b_i   = '0;
        op_c_i   = '0;
        instr_i  = NOTOKEN;
        xu_sel_i = XU_BYPASS;
        tag_i    = '0;
        for (int x = 0; x < 1024; x++)
            shadow[x] = fill_byte(x);
        for (int w = 0; w < 256; w++)
            u_mem.mem[w] = {fill_byte(4*w+3), fill_byte(4*w+2), fill_byte(4*w+1), fill_byte(4*w)};
        n = 0;
        while (rst_n_i !== 1'b1 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst_n_i !== 1'b1) begin
            fails++;
            $display("timeout while waiting for reset release");
        end else begin
            run_tests();
        end
        n = 0;
        while (exp_q.size() > 0 && n < 10) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            fails++;
            $display("timeout with %0d expected results never compared", exp_q.size());
        end
        $display("value errors %0d, other failures %0d", errors, fails);
        if (errors == 0 && fails == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule : tb_exec

//--- tests/data_mem_model.sv
//////////////////////////////////////////////////
// Data memory for the testbench, byte-enabled writes on the clock
// and read data valid within the cycle of the request
//////////////////////////////////////////////////

`timescale 1ns/100ps

module data_mem_model #(
    parameter int DEPTH = 256                // Words
) (
    input  logic            clk,
    input  exec_pkg::word_t addr_i,          // Word address from the DUT
    input  logic            rd_i,
    input  exec_pkg::be_t   be_i,
    input  exec_pkg::word_t wdata_i,         // Data already on its lanes
    output exec_pkg::word_t rdata_o
);

    import exec_pkg::*;

    localparam int AW = $clog2(DEPTH);

    word_t         mem [DEPTH];              // Preloaded by the testbench
    logic [AW-1:0] idx;

    assign idx     = addr_i[AW+1:2];
    assign rdata_o = rd_i ? mem[idx] : '0;   // Taken by the retire stage at the next edge

    always @(posedge clk) begin
        for (int n = 0; n < 4; n++) begin
            if (be_i[n])
                mem[idx][8*n +: 8] <= wdata_i[8*n +: 8];  // Enabled lanes only
        end
    end

endmodule : data_mem_model

//--- hw/exec_top.sv
//////////////////////////////////////////////////
// Execute and retire pipeline, two cycles from issue to write-back
//////////////////////////////////////////////////

`timescale 1ns/100ps

module exec_top #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_pkg::word_t  npc_i,
    input  exec_pkg::word_t  op_a_i,
    input  exec_pkg::word_t  op_b_i,
    input  exec_pkg::word_t  op_c_i,
    input  exec_pkg::instr_e instr_i,
    input  exec_pkg::xu_e    xu_sel_i,
    input  logic [TAG_W-1:0] tag_i,
    output exec_pkg::word_t  mem_addr_o,     // Data memory port
    output exec_pkg::word_t  mem_wdata_o,
    output logic             mem_rd_o,
    output exec_pkg::be_t    mem_be_o,
    input  exec_pkg::word_t  mem_rdata_i,
    output logic             wb_we_o,        // Register bank write
    output exec_pkg::word_t  wb_data_o,
    output logic [TAG_W-1:0] wb_tag_o,
    output logic             jump_o,         // Redirect
    output exec_pkg::word_t  jump_target_o
);

    import exec_pkg::*;

    word_t            ex_result, ex_target;  // Stage 1 to stage 2
    logic             ex_we, ex_jump;
    logic [1:0]       ex_offset;
    instr_e           ex_instr;
    logic [TAG_W-1:0] ex_tag;

    execute_stage #(.TAG_W(TAG_W)) u_execute (
        .clk(clk), .rst_n_i(rst_n_i), .npc_i(npc_i),
        .op_a_i(op_a_i), .op_b_i(op_b_i), .op_c_i(op_c_i),
        .instr_i(instr_i), .xu_sel_i(xu_sel_i), .tag_i(tag_i),
        .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
        .mem_rd_o(mem_rd_o), .mem_be_o(mem_be_o),
        .result_o(ex_result), .target_o(ex_target), .we_o(ex_we), .jump_o(ex_jump),
        .offset_o(ex_offset), .instr_o(ex_instr), .tag_o(ex_tag)
    );

    retire_stage #(.TAG_W(TAG_W)) u_retire (
        .clk(clk), .rst_n_i(rst_n_i),
        .result_i(ex_result), .target_i(ex_target), .mem_rdata_i(mem_rdata_i),
        .we_i(ex_we), .jump_i(ex_jump), .offset_i(ex_offset),
        .instr_i(ex_instr), .tag_i(ex_tag),
        .wb_we_o(wb_we_o), .wb_data_o(wb_data_o), .wb_tag_o(wb_tag_o),
        .jump_o(jump_o), .jump_target_o(jump_target_o)
    );

endmodule : exec_top

//--- hw/retire_stage.sv
//////////////////////////////////////////////////
// Second pipeline stage, load alignment and register write-back
//////////////////////////////////////////////////

`timescale 1ns/100ps

module retire_stage #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_pkg::word_t  result_i,       // Execute result
    input  exec_pkg::word_t  target_i,       // Branch target
    input  exec_pkg::word_t  mem_rdata_i,    // Word returned by the memory
    input  logic             we_i,
    input  logic             jump_i,
    input  logic [1:0]       offset_i,       // Byte lane of the load
    input  exec_pkg::instr_e instr_i,
    input  logic [TAG_W-1:0] tag_i,
    output logic             wb_we_o,
    output exec_pkg::word_t  wb_data_o,
    output logic [TAG_W-1:0] wb_tag_o,
    output logic             jump_o,
    output exec_pkg::word_t  jump_target_o
);

    import exec_pkg::*;

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       wb_data_nxt;

    assign byte_sel = mem_rdata_i[{offset_i, 3'b000} +: 8];
    assign half_sel = mem_rdata_i[{offset_i[1], 4'b0000} +: 16]; // Aligned half

    ////////// Load extension /////////////////////////
    always_comb begin
        case (instr_i)
            LB:      wb_data_nxt = {{24{byte_sel[7]}}, byte_sel};
            LBU:     wb_data_nxt = {24'd0, byte_sel};
            LH:      wb_data_nxt = {{16{half_sel[15]}}, half_sel};
            LHU:     wb_data_nxt = {16'd0, half_sel};
            LW:      wb_data_nxt = mem_rdata_i;
            default: wb_data_nxt = result_i;     // Non-loads pass through
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_we_o <= 1'b0;
            jump_o  <= 1'b0;
        end else begin
            wb_we_o <= we_i;
            jump_o  <= jump_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_data_o     <= wb_data_nxt;
        wb_tag_o      <= tag_i;
        jump_target_o <= target_i;
    end

endmodule : retire_stage

//--- hw/execute_stage.sv
//////////////////////////////////////////////////
// First pipeline stage, dispatches to one unit and registers the result
//////////////////////////////////////////////////

`timescale 1ns/100ps

module execute_stage #(
    parameter int TAG_W = 4
) (
    input  logic             clk,
    input  logic             rst_n_i,
    input  exec_pkg::word_t  npc_i,
    input  exec_pkg::word_t  op_a_i,
    input  exec_pkg::word_t  op_b_i,
    input  exec_pkg::word_t  op_c_i,
    input  exec_pkg::instr_e instr_i,
    input  exec_pkg::xu_e    xu_sel_i,
    input  logic [TAG_W-1:0] tag_i,
    output exec_pkg::word_t  mem_addr_o,
    output exec_pkg::word_t  mem_wdata_o,
    output logic             mem_rd_o,
    output exec_pkg::be_t    mem_be_o,
    output exec_pkg::word_t  result_o,
    output exec_pkg::word_t  target_o,
    output logic             we_o,
    output logic             jump_o,
    output logic [1:0]       offset_o,
    output exec_pkg::instr_e instr_o,
    output logic [TAG_W-1:0] tag_o
);

    import exec_pkg::*;

    logic   valid;                           // Select matches the class
    instr_e alu_instr, shift_instr, branch_instr, lsu_instr;
    word_t  alu_res, shift_res, br_target, br_link;
    logic   br_jump, br_we;
    word_t  lsu_addr, lsu_wdata;
    logic   [1:0] lsu_offset;
    logic   lsu_rd, lsu_we;
    be_t    lsu_be;
    word_t  result_nxt;
    logic   we_nxt;

    function automatic xu_e class_of(input instr_e instr);
        xu_e xu;
        case (instr)
            ADD, SUB, SLT, SLTU:                xu = XU_ADDER;
            XOR, OR, AND:                       xu = XU_LOGIC;
            SLL, SRL, SRA:                      xu = XU_SHIFT;
            BEQ, BNE, BLT, BGE, BLTU, BGEU,
            JAL, JALR:                          xu = XU_BRANCH;
            LB, LBU, LH, LHU, LW, SB, SH, SW:   xu = XU_MEMORY;
            default:                            xu = XU_BYPASS; // PASS
        endcase
        return xu;
    endfunction

    ////////// Dispatch ///////////////////////////////
    assign valid = (instr_i != NOTOKEN) && (class_of(instr_i) == xu_sel_i);

    assign alu_instr    = (valid && (xu_sel_i == XU_ADDER || xu_sel_i == XU_LOGIC)) ?
                          instr_i : NOTOKEN;
    assign shift_instr  = (valid && xu_sel_i == XU_SHIFT)  ? instr_i : NOTOKEN;
    assign branch_instr = (valid && xu_sel_i == XU_BRANCH) ? instr_i : NOTOKEN;
    assign lsu_instr    = (valid && xu_sel_i == XU_MEMORY) ? instr_i : NOTOKEN;

    alu_unit u_alu (.a_i(op_a_i), .b_i(op_b_i), .instr_i(alu_instr), .result_o(alu_res));

    shift_unit u_shift (.a_i(op_a_i), .shamt_i(op_b_i[4:0]), .instr_i(shift_instr),
                        .result_o(shift_res));

    branch_unit u_branch (.a_i(op_a_i), .b_i(op_b_i), .offset_i(op_c_i), .npc_i(npc_i),
                          .instr_i(branch_instr), .jump_o(br_jump), .target_o(br_target),
                          .link_o(br_link), .we_o(br_we));

    lsu_unit u_lsu (.a_i(op_a_i), .b_i(op_b_i), .data_i(op_c_i), .instr_i(lsu_instr),
                    .addr_o(lsu_addr), .offset_o(lsu_offset), .rd_o(lsu_rd), .be_o(lsu_be),
                    .wdata_o(lsu_wdata), .we_o(lsu_we));

    ////////// Result select //////////////////////////
    always_comb begin
        case (xu_sel_i)
            XU_ADDER, XU_LOGIC: result_nxt = alu_res;
            XU_SHIFT:           result_nxt = shift_res;
            XU_BRANCH:          result_nxt = br_link;    // Link value
            XU_MEMORY:          result_nxt = lsu_addr;   // Replaced by load data later
            default:            result_nxt = op_b_i;     // Bypass
        endcase
        if (!valid)
            we_nxt = 1'b0;                               // Bubble or bad select
        else if (xu_sel_i == XU_BRANCH)
            we_nxt = br_we;
        else if (xu_sel_i == XU_MEMORY)
            we_nxt = lsu_we;
        else
            we_nxt = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            we_o     <= 1'b0;
            jump_o   <= 1'b0;
            mem_rd_o <= 1'b0;
            mem_be_o <= '0;
            instr_o  <= NOTOKEN;
        end else begin
            we_o     <= we_nxt;
            jump_o   <= br_jump;                 // Zero unless a branch ran
            mem_rd_o <= lsu_rd;
            mem_be_o <= lsu_be;
            instr_o  <= valid ? instr_i : NOTOKEN;
        end
    end

    always_ff @(posedge clk) begin
        result_o    <= result_nxt;
        target_o    <= br_target;
        mem_addr_o  <= lsu_addr;
        mem_wdata_o <= lsu_wdata;
        offset_o    <= lsu_offset;
        tag_o       <= tag_i;
    end

endmodule : execute_stage

//--- hw/lsu_unit.sv
//////////////////////////////////////////////////
// Load/store address, byte enables and store lanes
// Misaligned halves and words align down
//////////////////////////////////////////////////

`timescale 1ns/100ps

module lsu_unit (
    input  exec_pkg::word_t  a_i,            // Base register
    input  exec_pkg::word_t  b_i,            // Offset
    input  exec_pkg::word_t  data_i,         // Store data
    input  exec_pkg::instr_e instr_i,
    output exec_pkg::word_t  addr_o,         // Word address, low bits zero
    output logic [1:0]       offset_o,       // Byte lane within the word
    output logic             rd_o,           // Read request
    output exec_pkg::be_t    be_o,           // Write byte enables
    output exec_pkg::word_t  wdata_o,        // Store data on its lanes
    output logic             we_o            // Load writes a register
);

    import exec_pkg::*;

    word_t ea;
    logic  is_load;

    assign ea       = a_i + b_i;             // Effective address
    assign addr_o   = {ea[31:2], 2'b00};
    assign offset_o = ea[1:0];

    always_comb begin
        case (instr_i)
            LB, LBU, LH, LHU, LW: is_load = 1'b1;
            default:              is_load = 1'b0;
        endcase
    end

    assign rd_o = is_load;
    assign we_o = is_load;                   // Stores write no register

    ////////// Store lanes ////////////////////////////
    always_comb begin
        case (instr_i)
            SB: begin
                be_o    = 4'b0001 << ea[1:0];    // One lane by offset
                wdata_o = {4{data_i[7:0]}};      // Byte on every lane
            end
            SH: begin
                be_o    = ea[1] ? 4'b1100 : 4'b0011; // Bit 0 ignored
                wdata_o = {2{data_i[15:0]}};
            end
            SW: begin
                be_o    = 4'b1111;
                wdata_o = data_i;
            end
            default: begin
                be_o    = '0;                    // Loads and bubbles
                wdata_o = '0;
            end
        endcase
    end

endmodule : lsu_unit

//--- hw/branch_unit.sv
//////////////////////////////////////////////////
// Branch condition, jump target and link value
//////////////////////////////////////////////////

`timescale 1ns/100ps

module branch_unit (
    input  exec_pkg::word_t  a_i,            // Compare operand / JALR base
    input  exec_pkg::word_t  b_i,            // Compare operand
    input  exec_pkg::word_t  offset_i,       // Immediate offset
    input  exec_pkg::word_t  npc_i,          // PC of the next instruction
    input  exec_pkg::instr_e instr_i,
    output logic             jump_o,
    output exec_pkg::word_t  target_o,
    output exec_pkg::word_t  link_o,
    output logic             we_o            // Link goes to the register bank
);

    import exec_pkg::*;

    logic  eq;
    logic  lt_s;
    logic  lt_u;
    word_t pc_rel;
    word_t jalr_sum;

    assign eq       = a_i == b_i;
    assign lt_s     = $signed(a_i) < $signed(b_i);
    assign lt_u     = a_i < b_i;
    assign pc_rel   = npc_i - 32'd4 + offset_i;  // Back to own PC, then offset
    assign jalr_sum = a_i + offset_i;

    always_comb begin
        case (instr_i)
            BEQ:       jump_o = eq;
            BNE:       jump_o = !eq;
            BLT:       jump_o = lt_s;
            BGE:       jump_o = !lt_s;
            BLTU:      jump_o = lt_u;
            BGEU:      jump_o = !lt_u;
            JAL, JALR: jump_o = 1'b1;            // Always taken
            default:   jump_o = 1'b0;
        endcase
    end

    // JALR clears bit 0 of the computed address
    assign target_o = (instr_i == JALR) ? {jalr_sum[31:1], 1'b0} : pc_rel;
    assign link_o   = npc_i;
    assign we_o     = (instr_i == JAL) || (instr_i == JALR); // Only jumps link

endmodule : branch_unit

//--- hw/shift_unit.sv
//////////////////////////////////////////////////
// Barrel shifter of the execute stage
//////////////////////////////////////////////////

`timescale 1ns/100ps

module shift_unit (
    input  exec_pkg::word_t  a_i,            // Value to shift
    input  logic [4:0]       shamt_i,        // Low five bits of operand B
    input  exec_pkg::instr_e instr_i,
    output exec_pkg::word_t  result_o
);

    import exec_pkg::*;

    always_comb begin
        case (instr_i)
            SLL:     result_o = a_i << shamt_i;
            SRL:     result_o = a_i >> shamt_i;             // Zero fill
            SRA:     result_o = $signed(a_i) >>> shamt_i;   // Sign fill
            default: result_o = '0;
        endcase
    end

endmodule : shift_unit

//--- hw/alu_unit.sv
//////////////////////////////////////////////////
// Adder and logic unit of the execute stage, purely combinational
//////////////////////////////////////////////////

`timescale 1ns/100ps

module alu_unit (
    input  exec_pkg::word_t  a_i,            // Operand A
    input  exec_pkg::word_t  b_i,            // Operand B
    input  exec_pkg::instr_e instr_i,        // NOTOKEN unless dispatched here
    output exec_pkg::word_t  result_o
);

    import exec_pkg::*;

    word_t sum;
    word_t diff;
    logic  lt_s;
    logic  lt_u;

    assign sum  = a_i + b_i;
    assign diff = a_i - b_i;
    assign lt_s = $signed(a_i) < $signed(b_i); // Signed compare for SLT
    assign lt_u = a_i < b_i;                   // Unsigned compare for SLTU

    always_comb begin
        case (instr_i)
            ADD:     result_o = sum;
            SUB:     result_o = diff;
            SLT:     result_o = {31'd0, lt_s};
            SLTU:    result_o = {31'd0, lt_u};
            XOR:     result_o = a_i ^ b_i;
            OR:      result_o = a_i | b_i;
            AND:     result_o = a_i & b_i;
            default: result_o = '0;            // Not an adder or logic op
        endcase
    end

endmodule : alu_unit

//--- hw/exec_pkg.sv
//////////////////////////////////////////////////
// Shared types for the RV32I execute/retire back end
// Import inside each module body of the pipeline
//////////////////////////////////////////////////

package exec_pkg;

    typedef logic [31:0] word_t;     // Data or address word
    typedef logic [3:0]  be_t;       // Byte enables, bit n for lane n

    ////////// Executed instructions //////////////////
    typedef enum logic [4:0] {
        NOTOKEN,                     // Bubble
        ADD,                         // Adder class
        SUB,
        SLT,
        SLTU,
        XOR,                         // Logic class
        OR,
        AND,
        SLL,                         // Shift class
        SRL,
        SRA,
        BEQ,                         // Conditional branches
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,                         // Unconditional jumps
        JALR,
        LB,                          // Loads
        LBU,
        LH,
        LHU,
        LW,
        SB,                          // Stores
        SH,
        SW,
        PASS                         // Bypass of operand B
    } instr_e;

    ////////// Execute unit selects ///////////////////
    typedef enum logic [2:0] {
        XU_ADDER,
        XU_LOGIC,
        XU_SHIFT,
        XU_BRANCH,
        XU_MEMORY,
        XU_BYPASS
    } xu_e;

endpackage : exec_pkg
